// File: tests/oven_vectors.txt
// scenario words at @00: op nibble (0 start, 1 stop, 2 clear), temp nibble, seconds byte
// picture rows at 40 + 8*pic, one word per row 0..7, each word {red, green}
@00 0003 0002 2000 0007 0004 0105 0001 0000
// heat pictures 0 to 4, red as shown with temp low
@40 0000 0000 0018 003c 003c 0018 0000 0000
@48 0000 0000 0038 007c 007c 0038 0000 0000
@50 0000 0000 003c 007e 007e 003c 0000 0000
@58 0000 003c 007e 007e 007e 007e 003c 0000
@60 003c 007e 00ff 00ff 00ff 00ff 007e 003c
// full
@68 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff
// red alarm icon
@80 0000 3800 4400 5a00 4a00 3200 c400 3800
// standby
@90 0000 0000 0018 003c 007e 007e 0024 0000
// red stop icon
@98 e000 6000 e000 3000 3100 3300 3e00 1c00

// File: files.f
rtl/ctrl_pkg.sv
rtl/panel_pkg.sv
rtl/cook_fsm.sv
rtl/cook_timer.sv
rtl/matrix_scan.sv
rtl/oven_panel_top.sv
tests/tb_oven_panel.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_oven_panel -f files.f -o oven_sim
	./obj_dir/oven_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_oven_panel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_oven_panel
    import ctrl_pkg::*;
    import panel_pkg::*;
();

    localparam int TICK_DIV = 20;
    localparam int SCAN_DIV = 2;

    localparam status_t all_clear  = '{busy: 1'b0, done: 1'b0, alarm: 1'b0};
    localparam status_t busy_only  = '{busy: 1'b1, done: 1'b0, alarm: 1'b0};
    localparam status_t done_only  = '{busy: 1'b0, done: 1'b1, alarm: 1'b0};
    localparam status_t alarm_only = '{busy: 1'b0, done: 1'b0, alarm: 1'b1};
    localparam cmd_t    stop_cmd   = '{op: op_stop, seconds: 8'd0};
    localparam cmd_t    clear_cmd  = '{op: op_clear, seconds: 8'd0};

    logic       clk = 1'b0;
    logic       rst;
    cmd_t       cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       temp;
    status_t    status;
    logic [7:0] row;
    col_pair_t  col;
    integer     seed;

    logic [15:0] vec_mem [0:159];
    cmd_t        scen_cmd [0:7];
    logic        scen_temp [0:7];
    col_pair_t   pic_rows [0:11][0:7];   // {red, green} per picture and row

    oven_panel_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .temp      (temp),
        .status    (status),
        .row       (row),
        .col       (col)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (exp !== act)
        begin
            $display("** Error [%s] status expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_col(input string name, input col_pair_t exp, input col_pair_t act);
        if (exp !== act)
        begin
            $display("** Error [%s] columns expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bits(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
        begin
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act < exp - 2 || act > exp + 2)
        begin
            $display("** Error [%s] latency expected %0d +/- 2, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic int row_index(input logic [7:0] r);
        int idx;
        idx = -1;
        for (int i = 0; i < 8; i++)
            if (r[i] == 1'b0)
                idx = i;
        return idx;
    endfunction

    // green icons turn orange when hot
    function automatic col_pair_t exp_col(input int p, input int r, input logic hot);
        col_pair_t c;
        c = pic_rows[p][r];
        if (hot && (p <= 7 || p == 9))
            c.red = c.green;
        return c;
    endfunction

    task automatic wait_row_step(output int cycles);
        logic [7:0] last;
        int         n;
        last = row;
        n = 0;
        next_cycle();
        while (row === last)
        begin
            n++;
            if (n > 4 * SCAN_DIV)
            begin
                $display("The row scan did not advance.");
                stop_with_failure();
            end
            next_cycle();
        end
        cycles = n + 1;
    endtask

    task automatic check_pic_frame(input string name, input int p, input logic hot);
        int cycles;
        int r;
        wait_row_step(cycles);    // may still carry the old picture
        r = row_index(row);
        for (int i = 0; i < 8; i++)
        begin
            wait_row_step(cycles);
            r = (r + 1) % 8;
            check_bits({name, " row"}, ~(8'h01 << r), row);
            check_bits({name, " step"}, 8'(SCAN_DIV), 8'(cycles));
            check_col(name, exp_col(p, r, hot), col);
        end
    endtask

    task automatic wait_status(input string name, input status_t want, input int limit);
        int n;
        n = 0;
        while (status !== want)
        begin
            if (n >= limit)
            begin
                $display("Status of %s never reached the expected value.", name);
                stop_with_failure();
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic send_cmd(input string name, input cmd_t c);
        int   gap;
        int   n;
        logic ok;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) next_cycle();
        cmd       = c;
        cmd_valid = 1'b1;
        ok = 1'b0;
        n = 0;
        while (!ok)
        begin
            @(negedge clk);
            ok = cmd_ready;
            next_cycle();
            n++;
            if (!ok && n > 10)
            begin
                $display("Command of %s was never accepted.", name);
                stop_with_failure();
            end
        end
        cmd_valid = 1'b0;
    endtask

    // starts right after the accepted start, counts cycles to done
    task automatic watch_heat(input string name, input int secs, input int hold);
        logic [7:0] last;
        int         cnt;
        last = row;
        cnt = 0;
        while (status.done !== 1'b1)
        begin
            next_cycle();
            cnt++;
            if (row !== last)
            begin
                check_col(name, exp_col(((cnt - 1) / TICK_DIV) % 5, row_index(row), 1'b0), col);
                last = row;
            end
            if (cnt <= hold)
            begin
                cmd       = (cnt <= hold / 2) ? scen_cmd[2] : scen_cmd[3];
                cmd_valid = 1'b1;
                #1;
                check_bits({name, " held"}, 8'h00, {7'd0, cmd_ready});
            end
            else
                cmd_valid = 1'b0;
            if (cnt > secs * TICK_DIV + 10)
            begin
                $display("The done flag of %s did not arrive in time.", name);
                stop_with_failure();
            end
        end
        check_latency(name, secs * TICK_DIV, cnt);
    endtask

    initial
    begin
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        temp      = 1'b0;
        seed      = 32'hfe01beac;
        $readmemh("tests/oven_vectors.txt", vec_mem);
        for (int i = 0; i < 8; i++)
        begin
            scen_cmd[i].op      = cmd_op_e'(vec_mem[i][13:12]);
            scen_cmd[i].seconds = vec_mem[i][7:0];
            scen_temp[i]        = vec_mem[i][8];
        end
        for (int p = 0; p < 12; p++)
            for (int r = 0; r < 8; r++)
                pic_rows[p][r] = vec_mem[64 + 8 * p + r];

        repeat (8) next_cycle();
        check_bits("reset row", 8'hff, row);
        check_col("reset col", '0, col);
        check_status("reset status", all_clear, status);
        check_bits("reset ready start", 8'h01, {7'd0, cmd_ready});
        cmd = clear_cmd;
        #1;
        check_bits("reset ready clear", 8'h00, {7'd0, cmd_ready});
        cmd = '0;
        repeat (8) next_cycle();
        rst = 1'b0;
        check_pic_frame("reset standby", 10, 1'b0);

        send_cmd("run start", scen_cmd[0]);
        check_status("run busy", busy_only, status);
        watch_heat("run frames", int'(scen_cmd[0].seconds), 0);
        check_pic_frame("run full", 5, 1'b0);
        send_cmd("run clear", clear_cmd);
        check_status("run cleared", all_clear, status);
        check_pic_frame("run standby", 10, 1'b0);

        send_cmd("backpressure start", scen_cmd[1]);
        watch_heat("backpressure", int'(scen_cmd[1].seconds),
                   4 + int'($unsigned($random(seed)) % 8));
        check_status("backpressure done", done_only, status);
        send_cmd("backpressure clear", clear_cmd);

        send_cmd("stop start", scen_cmd[4]);
        repeat (25) next_cycle();
        send_cmd("stop", stop_cmd);
        check_status("stop idle", all_clear, status);
        check_pic_frame("stop icon", 11, 1'b0);
        send_cmd("restart", scen_cmd[4]);
        check_status("restart busy", busy_only, status);
        send_cmd("second stop", stop_cmd);

        send_cmd("overheat start", scen_cmd[5]);
        repeat (10) next_cycle();
        temp = scen_temp[5];
        wait_status("overheat", alarm_only, 4);
        check_pic_frame("alarm icon", 8, 1'b1);
        temp = 1'b0;
        repeat (30) next_cycle();
        check_status("alarm held", alarm_only, status);
        send_cmd("alarm clear", clear_cmd);
        check_status("alarm cleared", all_clear, status);
        check_pic_frame("alarm standby", 10, 1'b0);

        send_cmd("color start", scen_cmd[6]);
        watch_heat("color run", int'(scen_cmd[6].seconds), 0);
        check_pic_frame("full cool", 5, 1'b0);
        temp = 1'b1;
        check_pic_frame("full hot", 5, 1'b1);
        send_cmd("color clear", clear_cmd);
        check_pic_frame("standby hot", 10, 1'b1);
        temp = 1'b0;

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/oven_panel_top.sv
`timescale 1ns/1ps
`default_nettype none

module oven_panel_top
    import ctrl_pkg::*;
    import panel_pkg::*;
#(
    parameter int TICK_DIV = 1000,
    parameter int SCAN_DIV = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  cmd_t       cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       temp,
    output status_t    status,
    output logic [7:0] row,
    output col_pair_t  col
);

    logic       timer_load;
    logic [7:0] timer_secs;
    logic       timer_stop;
    logic [7:0] elapsed;
    logic       expired;
    pic_e       pic;

    cook_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .temp       (temp),
        .elapsed    (elapsed),
        .expired    (expired),
        .status     (status),
        .timer_load (timer_load),
        .timer_secs (timer_secs),
        .timer_stop (timer_stop),
        .pic        (pic)
    );

    cook_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (timer_load),
        .secs    (timer_secs),
        .stop    (timer_stop),
        .elapsed (elapsed),
        .expired (expired)
    );

    matrix_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan (
        .clk  (clk),
        .rst  (rst),
        .pic  (pic),
        .temp (temp),
        .row  (row),
        .col  (col)
    );

endmodule

`default_nettype wire

// File: rtl/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan
    import panel_pkg::*;
#(
    parameter int SCAN_DIV = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  pic_e       pic,
    input  logic       temp,
    output logic [7:0] row,
    output col_pair_t  col
);

    localparam int DW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DW-1:0] div_cnt;
    logic [2:0]    row_cnt;
    logic          step;
    logic          started;
    logic [7:0]    green_nxt;
    logic [7:0]    red_nxt;

    function automatic logic [7:0] green_row(pic_e p, logic [2:0] r);
        logic [7:0] g;
        g = 8'h00;
        case (p)
            pic_heat0:
                case (r)
                    3'd2, 3'd5: g = 8'b0001_1000;
                    3'd3, 3'd4: g = 8'b0011_1100;
                    default:    g = 8'h00;
                endcase
            pic_heat1:
                case (r)
                    3'd2, 3'd5: g = 8'b0011_1000;
                    3'd3, 3'd4: g = 8'b0111_1100;
                    default:    g = 8'h00;
                endcase
            pic_heat2:
                case (r)
                    3'd2, 3'd5: g = 8'b0011_1100;
                    3'd3, 3'd4: g = 8'b0111_1110;
                    default:    g = 8'h00;
                endcase
            pic_heat3:
                case (r)
                    3'd1, 3'd6:             g = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: g = 8'b0111_1110;
                    default:                g = 8'h00;
                endcase
            pic_heat4:
                case (r)
                    3'd0, 3'd7: g = 8'b0011_1100;
                    3'd1, 3'd6: g = 8'b0111_1110;
                    default:    g = 8'b1111_1111;
                endcase
            pic_full: g = 8'b1111_1111;
            pic_aux6:
                case (r)
                    3'd0:    g = 8'b1100_0011;
                    3'd1:    g = 8'b1110_0011;
                    3'd2:    g = 8'b1111_0001;
                    3'd3:    g = 8'b1110_0011;
                    3'd4:    g = 8'b1100_0111;
                    3'd5:    g = 8'b1110_0111;
                    3'd6:    g = 8'b1111_0111;
                    default: g = 8'b1111_1011;
                endcase
            pic_aux7:
                case (r)
                    3'd1:    g = 8'b0000_0001;
                    3'd2:    g = 8'b1000_0001;
                    3'd3:    g = 8'b1100_0011;
                    3'd4:    g = 8'b1000_0011;
                    3'd5:    g = 8'b1100_0111;
                    3'd6:    g = 8'b1110_0111;
                    3'd7:    g = 8'b1111_0011;
                    default: g = 8'h00;
                endcase
            pic_aux9:
                case (r)
                    3'd2:    g = 8'b0110_0000;
                    3'd3:    g = 8'b1111_1100;
                    3'd4:    g = 8'b0011_1111;
                    3'd5:    g = 8'b0011_1110;
                    3'd6:    g = 8'b0001_1100;
                    default: g = 8'h00;
                endcase
            pic_standby:
                case (r)
                    3'd2:       g = 8'b0001_1000;
                    3'd3:       g = 8'b0011_1100;
                    3'd4, 3'd5: g = 8'b0111_1110;
                    3'd6:       g = 8'b0010_0100;
                    default:    g = 8'h00;
                endcase
            default: g = 8'h00;
        endcase
        return g;
    endfunction

    // red icons have their own table, the rest borrow green
    function automatic logic [7:0] red_row(pic_e p, logic [2:0] r, logic hot, logic [7:0] g);
        logic [7:0] c;
        c = 8'h00;
        case (p)
            pic_alarm:
                case (r)
                    3'd1:    c = 8'b0011_1000;
                    3'd2:    c = 8'b0100_0100;
                    3'd3:    c = 8'b0101_1010;
                    3'd4:    c = 8'b0100_1010;
                    3'd5:    c = 8'b0011_0010;
                    3'd6:    c = 8'b1100_0100;
                    3'd7:    c = 8'b0011_1000;
                    default: c = 8'h00;
                endcase
            pic_stop:
                case (r)
                    3'd0, 3'd2: c = 8'b1110_0000;
                    3'd1:       c = 8'b0110_0000;
                    3'd3:       c = 8'b0011_0000;
                    3'd4:       c = 8'b0011_0001;
                    3'd5:       c = 8'b0011_0011;
                    3'd6:       c = 8'b0011_1110;
                    default:    c = 8'b0001_1100;
                endcase
            pic_aux6, pic_aux7, pic_aux9: c = g;
            pic_heat0, pic_heat1, pic_heat2, pic_heat3, pic_heat4, pic_full:
                c = hot ? g : 8'h00;    // orange when hot
            default: c = 8'h00;
        endcase
        return c;
    endfunction

    assign step = (div_cnt == DW'(SCAN_DIV - 1));

    always_comb
    begin
        green_nxt = green_row(pic, row_cnt);
        red_nxt   = red_row(pic, row_cnt, temp, green_nxt);
    end

    // row and columns load on the same step
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            row_cnt <= 3'd0;
            row     <= 8'hff;
            col     <= '0;
            started <= 1'b0;
        end
        else
        begin
            div_cnt <= step ? '0 : div_cnt + 1'b1;
            if (step)
            begin
                row_cnt   <= row_cnt + 3'd1;
                row       <= ~(8'h01 << row_cnt);   // active low
                col.green <= green_nxt;
                col.red   <= red_nxt;
                started   <= 1'b1;
            end
        end
    end

    a_one_row: assert property (@(posedge clk) disable iff (rst)
        started |-> $onehot(~row));

endmodule

`default_nettype wire

// File: rtl/cook_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cook_timer #(
    parameter int TICK_DIV = 1000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] secs,
    input  logic       stop,
    output logic [7:0] elapsed,
    output logic       expired
);

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc;
    logic [7:0]    target;
    logic          running;
    logic          tick;

    // one second gone
    assign tick = running && (presc == PW'(TICK_DIV - 1));

    always_ff @(posedge clk)
    begin
        if (load)
            target <= secs;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            presc   <= '0;
            elapsed <= 8'd0;
            running <= 1'b0;
            expired <= 1'b0;
        end
        else
        begin
            expired <= 1'b0;
            if (load)
            begin
                running <= 1'b1;
                presc   <= '0;
                elapsed <= 8'd0;
            end
            else if (stop)
                running <= 1'b0;
            else if (running)
            begin
                presc <= tick ? '0 : presc + 1'b1;
                if (tick)
                begin
                    elapsed <= elapsed + 8'd1;
                    if (elapsed + 8'd1 == target)
                    begin
                        expired <= 1'b1;
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    a_no_reload: assert property (@(posedge clk) disable iff (rst)
        load |-> !running);

endmodule

`default_nettype wire

// File: rtl/cook_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cook_fsm
    import ctrl_pkg::*;
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cmd_t       cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       temp,
    input  logic [7:0] elapsed,
    input  logic       expired,
    output status_t    status,
    output logic       timer_load,
    output logic [7:0] timer_secs,
    output logic       timer_stop,
    output pic_e       pic
);

    cook_state_e state;
    logic        stopped;   // idle reached through a stop
    logic        accept;

    assign accept = cmd_valid && cmd_ready;

    // only the op that fits the state is taken, everything else waits
    always_comb
    begin
        case (state)
            st_idle: cmd_ready = (cmd.op == op_start);
            st_heat: cmd_ready = (cmd.op == op_stop);
            default: cmd_ready = (cmd.op == op_clear);
        endcase
    end

    assign timer_load = accept && (state == st_idle);
    assign timer_secs = cmd.seconds;
    assign timer_stop = (state == st_heat) && (accept || temp);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= st_idle;
            stopped <= 1'b0;
        end
        else
        begin
            if (accept)
                stopped <= 1'b0;
            case (state)
                st_idle:
                    if (accept)
                        state <= st_heat;
                st_heat:
                begin
                    if (accept)
                    begin
                        state   <= st_idle;
                        stopped <= 1'b1;
                    end
                    else if (temp)
                        state <= st_alarm;  // overheat wins over expiry
                    else if (expired)
                        state <= st_done;
                end
                default:
                    if (accept)
                        state <= st_idle;
            endcase
        end
    end

    always_comb
    begin
        status       = '0;
        status.busy  = (state == st_heat);
        status.done  = (state == st_done);
        status.alarm = (state == st_alarm);
    end

    always_comb
    begin
        case (state)
            st_idle: pic = stopped ? pic_stop : pic_standby;
            st_heat: pic = temp ? pic_alarm : pic_e'(4'(elapsed % 8'd5));
            st_done: pic = pic_full;
            default: pic = pic_alarm;
        endcase
    end

    a_ready_op: assert property (@(posedge clk) disable iff (rst)
        cmd_ready |-> ((cmd.op == op_start) == (state == st_idle)));

    a_expired_heat: assert property (@(posedge clk) disable iff (rst)
        expired |-> (state == st_heat));

endmodule

`default_nettype wire

// File: rtl/panel_pkg.sv
`default_nettype none

package panel_pkg;

    // picture numbers on the led matrix
    typedef enum logic [3:0]
    {
        pic_heat0   = 4'd0,
        pic_heat1   = 4'd1,
        pic_heat2   = 4'd2,
        pic_heat3   = 4'd3,
        pic_heat4   = 4'd4,
        pic_full    = 4'd5,
        pic_aux6    = 4'd6,     // not selected by the fsm
        pic_aux7    = 4'd7,
        pic_alarm   = 4'd8,
        pic_aux9    = 4'd9,
        pic_standby = 4'd10,
        pic_stop    = 4'd11
    } pic_e;

    // one column word per color, bit n lights column n
    typedef struct packed
    {
        logic [7:0] red;
        logic [7:0] green;
    } col_pair_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // host command opcodes
    typedef enum logic [1:0]
    {
        op_start = 2'd0,
        op_stop  = 2'd1,
        op_clear = 2'd2
    } cmd_op_e;

    typedef struct packed
    {
        cmd_op_e    op;
        logic [7:0] seconds;    // cook time in whole seconds
    } cmd_t;

    typedef enum logic [1:0]
    {
        st_idle  = 2'd0,
        st_heat  = 2'd1,
        st_done  = 2'd2,
        st_alarm = 2'd3
    } cook_state_e;

    typedef struct packed
    {
        logic busy;
        logic done;
        logic alarm;
    } status_t;

endpackage

`default_nettype wire
